//--- hdl/pid_pkg.sv
package pid_pkg;

    // ------------------------------------------------------------------------
    // Widths and channel count
    // ------------------------------------------------------------------------
    localparam int N_CHAN     = 4;
    localparam int W_CHAN     = 2;
    localparam int W_DATA_IN  = 16;
    localparam int W_COEFS    = 16;
    localparam int W_DATA_OUT = 32;
    localparam int W_WR_DATA  = 32;
    // Register address width
    localparam int W_WR_ADDR  = 3;

    // ------------------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------------------
    typedef logic [W_CHAN-1:0]            pid_chan_t;
    typedef logic signed [W_DATA_IN-1:0]  pid_sample_t;
    typedef logic signed [W_COEFS-1:0]    pid_coef_t;
    typedef logic signed [W_DATA_OUT-1:0] pid_out_t;

    // Register map, one entry set per channel
    typedef enum logic [W_WR_ADDR-1:0] {
        CLR_ADDR      = 3'd0,
        SETPOINT_ADDR = 3'd1,
        P_COEF_ADDR   = 3'd2,
        I_COEF_ADDR   = 3'd3,
        D_COEF_ADDR   = 3'd4
    } pid_reg_addr_t;

    // ------------------------------------------------------------------------
    // Write word views
    // ------------------------------------------------------------------------
    // Raw bits, bit 0 doubles as the clear flag
    // Setpoint view, entry 0 holds the low sample
    // Coefficient view, entry 0 holds the low coefficient
    typedef union packed {
        logic [W_WR_DATA-1:0]                      raw;
        pid_sample_t [W_WR_DATA/W_DATA_IN-1:0]     sp_view;
        pid_coef_t [W_WR_DATA/W_COEFS-1:0]         coef_view;
    } pid_wr_data_u;

endpackage

//--- hdl/pid_credit_if.sv
interface pid_credit_if;
    import pid_pkg::*;

    // One item per cycle while valid is high
    logic      valid;
    pid_chan_t chan;
    pid_out_t  data;
    // Single-cycle pulse from the receiver, one per freed slot
    logic      credit;

    // Sending side, spends credits
    modport producer (
        output valid,
        output chan,
        output data,
        input  credit
    );

    // Receiving side, never refuses an item
    modport consumer (
        input  valid,
        input  chan,
        input  data,
        output credit
    );

endinterface

//--- hdl/pid_coef_regs.sv
module pid_coef_regs (
    input  logic                  sys_clk_in,
    input  logic                  arst_n,
    // Register write port
    input  logic                  wr_en,
    input  pid_pkg::pid_reg_addr_t wr_addr,
    input  pid_pkg::pid_chan_t    wr_chan,
    input  pid_pkg::pid_wr_data_u wr_data,
    // Per-channel configuration toward the filter
    output pid_pkg::pid_sample_t  setpoint [pid_pkg::N_CHAN],
    output pid_pkg::pid_coef_t    p_coef [pid_pkg::N_CHAN],
    output pid_pkg::pid_coef_t    i_coef [pid_pkg::N_CHAN],
    output pid_pkg::pid_coef_t    d_coef [pid_pkg::N_CHAN],
    output logic [pid_pkg::N_CHAN-1:0] clr
);
    import pid_pkg::*;

    // ------------------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------------------
    // Writes land on the enabled edge
    // The filter reads these combinationally, so a write
    // is seen by samples from the next cycle on
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            // All channels start unconfigured
            for (int c = 0; c < N_CHAN; c++) begin
                setpoint[c] <= '0;
                p_coef[c]   <= '0;
                i_coef[c]   <= '0;
                d_coef[c]   <= '0;
            end
            clr <= '0;
        end else if (wr_en) begin
            // Address selects which view of the word is stored
            case (wr_addr)
                CLR_ADDR: begin
                    // Flag only, upper bits ignored
                    clr[wr_chan] <= wr_data.raw[0];
                end
                SETPOINT_ADDR: begin
                    setpoint[wr_chan] <= wr_data.sp_view[0];
                end
                P_COEF_ADDR: begin
                    p_coef[wr_chan] <= wr_data.coef_view[0];
                end
                I_COEF_ADDR: begin
                    i_coef[wr_chan] <= wr_data.coef_view[0];
                end
                D_COEF_ADDR: begin
                    d_coef[wr_chan] <= wr_data.coef_view[0];
                end
                default: begin
                    // Unmapped address, write is dropped
                end
            endcase
        end
    end

endmodule

//--- hdl/pid_filter.sv
module pid_filter #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 sys_clk_in,
    input  logic                 arst_n,
    // Sample port
    input  logic                 sample_valid,
    input  pid_pkg::pid_chan_t   sample_chan,
    input  pid_pkg::pid_sample_t sample_data,
    output logic                 sample_ready,
    // Configuration from the register block
    input  pid_pkg::pid_sample_t setpoint [pid_pkg::N_CHAN],
    input  pid_pkg::pid_coef_t   p_coef [pid_pkg::N_CHAN],
    input  pid_pkg::pid_coef_t   i_coef [pid_pkg::N_CHAN],
    input  pid_pkg::pid_coef_t   d_coef [pid_pkg::N_CHAN],
    input  logic [pid_pkg::N_CHAN-1:0] clr,
    // Results toward the FIFO
    pid_credit_if.producer       to_fifo
);
    import pid_pkg::*;

    // Full-precision widths, no wrap anywhere before saturation
    localparam int W_ERROR = W_DATA_IN + 1;
    localparam int W_K     = W_COEFS + 2;
    localparam int W_PROD  = W_K + W_ERROR;
    // Three products plus the previous output
    localparam int W_SUM   = W_PROD + 2;
    localparam int W_CRED  = $clog2(FIFO_DEPTH + 1);

    localparam pid_out_t MAX_OUT = {1'b0, {(W_DATA_OUT-1){1'b1}}};
    localparam pid_out_t MIN_OUT = {1'b1, {(W_DATA_OUT-1){1'b0}}};

    // Per-channel history
    logic signed [W_ERROR-1:0] err_hist0 [N_CHAN];
    logic signed [W_ERROR-1:0] err_hist1 [N_CHAN];
    pid_out_t                  out_hist [N_CHAN];

    // Credits not yet claimed by a sample in flight
    logic [W_CRED-1:0] credit_cnt;
    logic              accept;
    logic              s1_load;

    // Stage 1 inputs
    logic signed [W_ERROR-1:0] err;

    // Stage registers
    logic                      s1_valid;
    pid_chan_t                 s1_chan;
    logic signed [W_ERROR-1:0] s1_err;
    logic signed [W_ERROR-1:0] s1_e1;
    logic signed [W_ERROR-1:0] s1_e2;
    logic signed [W_K-1:0]     s1_k1;
    logic signed [W_K-1:0]     s1_k2;
    logic signed [W_K-1:0]     s1_k3;

    logic                      s2_valid;
    pid_chan_t                 s2_chan;
    logic signed [W_PROD-1:0]  s2_prod0;
    logic signed [W_PROD-1:0]  s2_prod1;
    logic signed [W_PROD-1:0]  s2_prod2;

    logic                      s3_valid;
    pid_chan_t                 s3_chan;
    pid_out_t                  s3_data;

    // Stage 3 sum and clamp
    logic signed [W_SUM-1:0]   sum;
    pid_out_t                  sat;

    // ------------------------------------------------------------------------
    // Input handshake and credit count
    // ------------------------------------------------------------------------
    assign sample_ready = (credit_cnt != '0);
    assign accept       = sample_valid && sample_ready;
    // Samples of a cleared channel are taken but go nowhere
    assign s1_load      = accept && !clr[sample_chan];

    // Spent at acceptance, so the stages in flight are covered
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= W_CRED'(FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - W_CRED'(s1_load) + W_CRED'(to_fifo.credit);
        end
    end

    // ------------------------------------------------------------------------
    // Stage 1: error, z-domain gains, history fetch
    // ------------------------------------------------------------------------
    assign err = setpoint[sample_chan] - sample_data;

    always_ff @(posedge sys_clk_in) begin
        s1_chan <= sample_chan;
        s1_err  <= err;
        s1_e1   <= err_hist0[sample_chan];
        s1_e2   <= err_hist1[sample_chan];
        // k1 = P + I + D, k2 = -P - 2D, k3 = D
        s1_k1   <= p_coef[sample_chan] + i_coef[sample_chan] + d_coef[sample_chan];
        s1_k2   <= -p_coef[sample_chan] - (d_coef[sample_chan] <<< 1);
        s1_k3   <= d_coef[sample_chan];
    end

    // ------------------------------------------------------------------------
    // Stage 2: coefficient-error products
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk_in) begin
        s2_chan  <= s1_chan;
        s2_prod0 <= s1_k1 * s1_err;
        s2_prod1 <= s1_k2 * s1_e1;
        s2_prod2 <= s1_k3 * s1_e2;
    end

    // ------------------------------------------------------------------------
    // Stage 3: accumulate onto previous output, saturate
    // ------------------------------------------------------------------------
    // Previous output read here and written back on the same edge
    always_comb begin
        sum = out_hist[s2_chan] + s2_prod0 + s2_prod1 + s2_prod2;
        if (sum > MAX_OUT) begin
            sat = MAX_OUT;
        end else if (sum < MIN_OUT) begin
            sat = MIN_OUT;
        end else begin
            sat = pid_out_t'(sum);
        end
    end

    always_ff @(posedge sys_clk_in) begin
        s3_chan <= s2_chan;
        s3_data <= sat;
    end

    // Valid bits only
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= s1_load;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // ------------------------------------------------------------------------
    // History update
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < N_CHAN; c++) begin
                err_hist0[c] <= '0;
                err_hist1[c] <= '0;
                out_hist[c]  <= '0;
            end
        end else begin
            // Shift the error pair at acceptance
            if (s1_load) begin
                err_hist0[sample_chan] <= err;
                err_hist1[sample_chan] <= err_hist0[sample_chan];
            end
            if (s2_valid) begin
                out_hist[s2_chan] <= sat;
            end
            // Clear wins over any write in the same cycle
            for (int c = 0; c < N_CHAN; c++) begin
                if (clr[c]) begin
                    err_hist0[c] <= '0;
                    err_hist1[c] <= '0;
                    out_hist[c]  <= '0;
                end
            end
        end
    end

    // Result toward the FIFO, three edges after acceptance
    assign to_fifo.valid = s3_valid;
    assign to_fifo.chan  = s3_chan;
    assign to_fifo.data  = s3_data;

endmodule

//--- hdl/pid_result_fifo.sv
module pid_result_fifo #(
    parameter int FIFO_DEPTH = 8,
    parameter int PORT_DEPTH = 2
) (
    input  logic           sys_clk_in,
    input  logic           arst_n,
    pid_credit_if.consumer from_filt,
    pid_credit_if.producer to_port
);
    import pid_pkg::*;

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int CRED_W = $clog2(PORT_DEPTH + 1);

    // Storage, payload only
    pid_chan_t chan_mem [FIFO_DEPTH];
    pid_out_t  data_mem [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    // Free slots known in the output stage
    logic [CRED_W-1:0] credit_cnt;
    logic              send;

    // Head leaves whenever the output stage has room
    assign send = (count != '0) && (credit_cnt != '0);

    assign to_port.valid    = send;
    assign to_port.chan     = chan_mem[rd_ptr];
    assign to_port.data     = data_mem[rd_ptr];
    // Slot freed in the same cycle the head is sent
    assign from_filt.credit = send;

    // Write side, never refuses since the filter spends credits
    always_ff @(posedge sys_clk_in) begin
        if (from_filt.valid) begin
            chan_mem[wr_ptr] <= from_filt.chan;
            data_mem[wr_ptr] <= from_filt.data;
        end
    end

    // Pointers, occupancy, downstream credits
    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRED_W'(PORT_DEPTH);
        end else begin
            if (from_filt.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count + CNT_W'(from_filt.valid) - CNT_W'(send);
            credit_cnt <= credit_cnt - CRED_W'(send) + CRED_W'(to_port.credit);
        end
    end

endmodule

//--- hdl/pid_result_port.sv
module pid_result_port #(
    parameter int PORT_DEPTH = 2
) (
    input  logic               sys_clk_in,
    input  logic               arst_n,
    pid_credit_if.consumer     from_fifo,
    // Outside handshake
    output logic               out_valid,
    output pid_pkg::pid_chan_t out_chan,
    output pid_pkg::pid_out_t  out_data,
    input  logic               out_ready
);
    import pid_pkg::*;

    localparam int CNT_W = $clog2(PORT_DEPTH + 1);

    // Shift queue, oldest entry always at index 0
    pid_chan_t        q_chan [PORT_DEPTH];
    pid_out_t         q_data [PORT_DEPTH];
    logic [CNT_W-1:0] count;
    logic             pop;
    logic [CNT_W-1:0] wr_idx;

    assign out_valid = (count != '0);
    assign out_chan  = q_chan[0];
    assign out_data  = q_data[0];
    assign pop       = out_valid && out_ready;
    // One credit back per delivered result
    assign from_fifo.credit = pop;

    // New entry goes behind the last one left after a pop
    assign wr_idx = pop ? count - 1'b1 : count;

    always_ff @(posedge sys_clk_in) begin
        if (pop) begin
            for (int i = 0; i < PORT_DEPTH - 1; i++) begin
                q_chan[i] <= q_chan[i+1];
                q_data[i] <= q_data[i+1];
            end
        end
        // Later assignment overrides the shift at the write slot
        if (from_fifo.valid) begin
            for (int i = 0; i < PORT_DEPTH; i++) begin
                if (CNT_W'(i) == wr_idx) begin
                    q_chan[i] <= from_fifo.chan;
                    q_data[i] <= from_fifo.data;
                end
            end
        end
    end

    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(from_fifo.valid) - CNT_W'(pop);
        end
    end

endmodule

//--- hdl/pid_top.sv
module pid_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int PORT_DEPTH = 2
) (
    input  logic                          sys_clk_in,
    input  logic                          arst_n,
    // Register port
    input  logic                          wr_en,
    input  pid_pkg::pid_reg_addr_t        wr_addr,
    input  pid_pkg::pid_chan_t            wr_chan,
    input  logic [pid_pkg::W_WR_DATA-1:0] wr_data,
    // Sample port
    input  logic                          sample_valid,
    input  pid_pkg::pid_chan_t            sample_chan,
    input  pid_pkg::pid_sample_t          sample_data,
    output logic                          sample_ready,
    // Result port
    output logic                          out_valid,
    output pid_pkg::pid_chan_t            out_chan,
    output pid_pkg::pid_out_t             out_data,
    input  logic                          out_ready
);
    import pid_pkg::*;

    // Configuration arrays
    pid_sample_t        setpoint [N_CHAN];
    pid_coef_t          p_coef [N_CHAN];
    pid_coef_t          i_coef [N_CHAN];
    pid_coef_t          d_coef [N_CHAN];
    logic [N_CHAN-1:0]  clr;

    // Credit links
    pid_credit_if filt_to_fifo ();
    pid_credit_if fifo_to_port ();

    pid_coef_regs u_coef_regs (
        .sys_clk_in (sys_clk_in),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_chan    (wr_chan),
        .wr_data    (wr_data),
        .setpoint   (setpoint),
        .p_coef     (p_coef),
        .i_coef     (i_coef),
        .d_coef     (d_coef),
        .clr        (clr)
    );

    pid_filter #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_filter (
        .sys_clk_in   (sys_clk_in),
        .arst_n       (arst_n),
        .sample_valid (sample_valid),
        .sample_chan  (sample_chan),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .setpoint     (setpoint),
        .p_coef       (p_coef),
        .i_coef       (i_coef),
        .d_coef       (d_coef),
        .clr          (clr),
        .to_fifo      (filt_to_fifo.producer)
    );

    pid_result_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PORT_DEPTH (PORT_DEPTH)
    ) u_result_fifo (
        .sys_clk_in (sys_clk_in),
        .arst_n     (arst_n),
        .from_filt  (filt_to_fifo.consumer),
        .to_port    (fifo_to_port.producer)
    );

    pid_result_port #(
        .PORT_DEPTH (PORT_DEPTH)
    ) u_result_port (
        .sys_clk_in (sys_clk_in),
        .arst_n     (arst_n),
        .from_fifo  (fifo_to_port.consumer),
        .out_valid  (out_valid),
        .out_chan   (out_chan),
        .out_data   (out_data),
        .out_ready  (out_ready)
    );

endmodule

//--- tb/pid_assertions.sv
module pid_assertions #(
    parameter int FIFO_DEPTH = 8,
    parameter int PORT_DEPTH = 2
) (
    input logic               sys_clk_in,
    input logic               arst_n,
    input logic               f2f_valid,
    input logic               f2f_credit,
    input logic               f2p_valid,
    input logic               out_valid,
    input logic               out_ready,
    input pid_pkg::pid_chan_t out_chan,
    input pid_pkg::pid_out_t  out_data
);

    // Credits held by the filter as seen on the link
    int f2f_held;
    // Free port slots follow the results leaving the design
    int f2p_held;

    always_ff @(posedge sys_clk_in or negedge arst_n) begin
        if (!arst_n) begin
            f2f_held <= FIFO_DEPTH;
            f2p_held <= PORT_DEPTH;
        end else begin
            f2f_held <= f2f_held - int'(f2f_valid) + int'(f2f_credit);
            f2p_held <= f2p_held - int'(f2p_valid) + int'(out_valid && out_ready);
        end
    end

    // Each item must be covered by a credit
    a_f2f_credit: assert property (@(posedge sys_clk_in) disable iff (!arst_n)
        f2f_valid |-> f2f_held > 0)
        else $error("filter sent a result without a credit");

    a_f2p_credit: assert property (@(posedge sys_clk_in) disable iff (!arst_n)
        f2p_valid |-> f2p_held > 0)
        else $error("FIFO sent a result without a credit");

    // Stalled output holds still
    a_out_stable: assert property (@(posedge sys_clk_in) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_chan) && $stable(out_data))
        else $error("output changed while stalled");

    a_reset_idle: assert property (@(posedge sys_clk_in)
        !arst_n || $rose(arst_n) |-> !out_valid)
        else $error("out_valid high in or right after reset");

endmodule

bind pid_top pid_assertions #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .PORT_DEPTH (PORT_DEPTH)
) u_assertions (
    .sys_clk_in (sys_clk_in),
    .arst_n     (arst_n),
    .f2f_valid  (filt_to_fifo.valid),
    .f2f_credit (filt_to_fifo.credit),
    .f2p_valid  (fifo_to_port.valid),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_chan   (out_chan),
    .out_data   (out_data)
);

//--- tb/pid_tb.sv
module pid_tb;
    import pid_pkg::*;

    localparam int FIFO_DEPTH    = 8;
    localparam int PORT_DEPTH    = 2;
    // Bounds in clock cycles
    localparam int READY_TIMEOUT = 1000;
    localparam int DRAIN_TIMEOUT = 4000;
    // Table entry kinds
    localparam int ENT_WR    = 0;
    localparam int ENT_SMP   = 1;
    localparam int ENT_DRAIN = 2;
    localparam int ENT_RAND  = 3;
    // Signed limits of the result word
    localparam longint OUT_MAX = (longint'(1) <<< (W_DATA_OUT - 1)) - 1;
    localparam longint OUT_MIN = -(longint'(1) <<< (W_DATA_OUT - 1));

    logic                 sys_clk_in;
    logic                 arst_n;
    logic                 wr_en;
    pid_reg_addr_t        wr_addr;
    pid_chan_t            wr_chan;
    logic [W_WR_DATA-1:0] wr_data;
    logic                 sample_valid;
    pid_chan_t            sample_chan;
    pid_sample_t          sample_data;
    logic                 sample_ready;
    logic                 out_valid;
    pid_chan_t            out_chan;
    pid_out_t             out_data;
    logic                 out_ready;

    // Stimulus table, one column per queue
    int                   tab_kind [$];
    pid_reg_addr_t        tab_addr [$];
    pid_chan_t            tab_chan [$];
    logic [W_WR_DATA-1:0] tab_val [$];
    logic                 tab_drop [$];
    pid_out_t             tab_exp [$];

    // Reference model state per channel
    longint m_sp [N_CHAN];
    longint m_p [N_CHAN];
    longint m_i [N_CHAN];
    longint m_d [N_CHAN];
    longint m_e1 [N_CHAN];
    longint m_e2 [N_CHAN];
    longint m_y [N_CHAN];
    logic   m_clr [N_CHAN];

    // Results still owed by the DUT
    pid_out_t  exp_data [N_CHAN][$];
    pid_chan_t exp_chan [$];

    int   seed;
    logic random_ready;
    logic saw_stall;
    logic aborted;
    int   chan_errs;
    int   data_errs;
    int   misc_errs;

    pid_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PORT_DEPTH (PORT_DEPTH)
    ) DUT (.*);

    initial begin
        sys_clk_in = 1'b0;
        forever #50 sys_clk_in = ~sys_clk_in;
    end

    // ------------------------------------------------------------------------
    // Reference model and table construction
    // ------------------------------------------------------------------------
    function automatic void push_entry(int kind, pid_reg_addr_t a, pid_chan_t c,
                                       logic [W_WR_DATA-1:0] v, logic drop, pid_out_t exp);
        tab_kind.push_back(kind);
        tab_addr.push_back(a);
        tab_chan.push_back(c);
        tab_val.push_back(v);
        tab_drop.push_back(drop);
        tab_exp.push_back(exp);
    endfunction

    function automatic void add_wr(pid_reg_addr_t a, pid_chan_t c, logic [W_WR_DATA-1:0] v);
        longint lo;
        lo = longint'($signed(v[15:0]));
        case (a)
            CLR_ADDR: begin
                m_clr[c] = v[0];
                // History is held at zero while the bit is set
                if (v[0]) begin
                    m_e1[c] = 0;
                    m_e2[c] = 0;
                    m_y[c]  = 0;
                end
            end
            SETPOINT_ADDR: m_sp[c] = lo;
            P_COEF_ADDR:   m_p[c] = lo;
            I_COEF_ADDR:   m_i[c] = lo;
            D_COEF_ADDR:   m_d[c] = lo;
            default: begin
            end
        endcase
        push_entry(ENT_WR, a, c, v, 1'b0, '0);
    endfunction

    function automatic void add_smp(pid_chan_t c, int data);
        pid_sample_t s;
        longint      e;
        longint      y;
        s = pid_sample_t'(data);
        if (m_clr[c]) begin
            // Cleared channel, accepted but no result
            push_entry(ENT_SMP, CLR_ADDR, c, {16'h0, s}, 1'b1, '0);
        end else begin
            e = m_sp[c] - longint'(s);
            // Velocity form, k1 = P+I+D, k2 = -P-2D, k3 = D
            y = m_y[c] + (m_p[c] + m_i[c] + m_d[c]) * e
                + (-m_p[c] - 2 * m_d[c]) * m_e1[c] + m_d[c] * m_e2[c];
            if (y > OUT_MAX) begin
                y = OUT_MAX;
            end else if (y < OUT_MIN) begin
                y = OUT_MIN;
            end
            m_e2[c] = m_e1[c];
            m_e1[c] = e;
            m_y[c]  = y;
            push_entry(ENT_SMP, CLR_ADDR, c, {16'h0, s}, 1'b0, pid_out_t'(y));
        end
    endfunction

    function automatic void add_ctl(int kind, logic [W_WR_DATA-1:0] v);
        push_entry(kind, CLR_ADDR, '0, v, 1'b0, '0);
    endfunction

    function automatic void build_table();
        int pat [12] = '{0, 1, 1, 2, 3, 3, 0, 2, 1, 0, 3, 2};
        for (int c = 0; c < N_CHAN; c++) begin
            m_sp[c] = 0;
            m_p[c] = 0;
            m_i[c] = 0;
            m_d[c] = 0;
            m_e1[c] = 0;
            m_e2[c] = 0;
            m_y[c] = 0;
            m_clr[c] = 1'b0;
        end
        // Unconfigured channels give zero
        add_smp(0, 100);
        add_smp(3, -5);
        add_ctl(ENT_DRAIN, 0);
        // Single channel sequence
        add_wr(SETPOINT_ADDR, 0, 1000);
        add_wr(P_COEF_ADDR, 0, 3);
        add_wr(I_COEF_ADDR, 0, 1);
        add_wr(D_COEF_ADDR, 0, 2);
        add_smp(0, 900);
        add_smp(0, 950);
        add_smp(0, 1010);
        add_smp(0, 1100);
        add_smp(0, 990);
        add_ctl(ENT_DRAIN, 0);
        // Interleaved, with back-to-back repeats of one channel
        add_wr(SETPOINT_ADDR, 1, -200);
        add_wr(P_COEF_ADDR, 1, 5);
        add_wr(I_COEF_ADDR, 1, 2);
        add_wr(D_COEF_ADDR, 1, -1);
        add_wr(P_COEF_ADDR, 2, -4);
        add_wr(I_COEF_ADDR, 2, 3);
        add_wr(D_COEF_ADDR, 2, 1);
        add_wr(SETPOINT_ADDR, 3, 500);
        add_wr(P_COEF_ADDR, 3, 1);
        add_wr(I_COEF_ADDR, 3, 1);
        add_wr(D_COEF_ADDR, 3, 1);
        for (int i = 0; i < 12; i++) begin
            add_smp(pid_chan_t'(pat[i]), i * 53 - 300);
        end
        add_ctl(ENT_DRAIN, 0);
        // Saturation, first high then low
        add_wr(SETPOINT_ADDR, 2, 32'h7fff);
        add_wr(P_COEF_ADDR, 2, 32'h7fff);
        add_wr(I_COEF_ADDR, 2, 32'h7fff);
        add_wr(D_COEF_ADDR, 2, 0);
        add_smp(2, -32768);
        add_smp(2, -32768);
        add_wr(SETPOINT_ADDR, 2, 32'h8000);
        add_smp(2, 32767);
        add_smp(2, 32767);
        add_ctl(ENT_DRAIN, 0);
        // Clear on channel 1 while channel 0 keeps running
        add_wr(CLR_ADDR, 1, 1);
        add_smp(1, 10);
        add_smp(0, 970);
        add_smp(1, 20);
        add_smp(1, 30);
        add_wr(CLR_ADDR, 1, 0);
        add_smp(1, -150);
        add_smp(0, 1005);
        add_smp(1, -180);
        add_smp(1, -210);
        add_ctl(ENT_DRAIN, 0);
        // Calm channel 2 down before the stress run
        add_wr(CLR_ADDR, 2, 1);
        add_wr(CLR_ADDR, 2, 0);
        add_wr(SETPOINT_ADDR, 2, 0);
        add_wr(P_COEF_ADDR, 2, 2);
        add_wr(I_COEF_ADDR, 2, 1);
        // Back-pressure run
        add_ctl(ENT_RAND, 1);
        for (int i = 0; i < 40; i++) begin
            add_smp(pid_chan_t'((i % 5 == 4) ? (i - 1) % 4 : i % 4), (i * 97) % 2000 - 1000);
        end
        add_ctl(ENT_DRAIN, 0);
        add_ctl(ENT_RAND, 0);
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_chan(input pid_chan_t got, input pid_chan_t exp);
        if (got !== exp) begin
            $display("Error at %0t: result channel %0d, expected %0d", $time, got, exp);
            chan_errs++;
        end
    endtask

    task automatic check_data(input pid_out_t got, input pid_out_t exp, input pid_chan_t c);
        if (got !== exp) begin
            $display("Error at %0t: channel %0d result %0d, expected %0d", $time, c, got, exp);
            data_errs++;
        end
    endtask

    task automatic take_result();
        pid_chan_t c;
        c = out_chan;
        if (exp_chan.size() == 0) begin
            $display("Unexpected result on channel %0d with value %0d", c, out_data);
            misc_errs++;
        end else begin
            // Single pipeline, so global order is kept too
            check_chan(c, exp_chan.pop_front());
            if (exp_data[c].size() == 0) begin
                $display("Result on channel %0d arrived with none owed", c);
                misc_errs++;
            end else begin
                check_data(out_data, exp_data[c].pop_front(), c);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Output side, ready pattern and result capture on the falling edge
    // ------------------------------------------------------------------------
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge sys_clk_in);
            if (random_ready) begin
                // Roughly one cycle in four
                out_ready = (($random(seed) & 3) == 0);
            end else begin
                out_ready = 1'b1;
            end
            if (random_ready && !sample_ready) begin
                saw_stall = 1'b1;
            end
            // Handshake completes on the coming rising edge
            if (arst_n && out_valid && out_ready) begin
                take_result();
            end
        end
    end

    task automatic apply_entry(input int n);
        int waited;
        waited = 0;
        @(negedge sys_clk_in);
        wr_en        = 1'b0;
        sample_valid = 1'b0;
        case (tab_kind[n])
            ENT_WR: begin
                wr_en   = 1'b1;
                wr_addr = tab_addr[n];
                wr_chan = tab_chan[n];
                wr_data = tab_val[n];
            end
            ENT_SMP: begin
                while (!sample_ready && waited < READY_TIMEOUT) begin
                    @(negedge sys_clk_in);
                    waited++;
                end
                if (!sample_ready) begin
                    $display("Timeout: sample_ready stayed low for %0d cycles", waited);
                    misc_errs++;
                    aborted = 1'b1;
                end else begin
                    sample_valid = 1'b1;
                    sample_chan  = tab_chan[n];
                    sample_data  = tab_val[n][W_DATA_IN-1:0];
                    if (!tab_drop[n]) begin
                        exp_chan.push_back(tab_chan[n]);
                        exp_data[tab_chan[n]].push_back(tab_exp[n]);
                    end
                end
            end
            ENT_DRAIN: begin
                while (exp_chan.size() != 0 && waited < DRAIN_TIMEOUT) begin
                    @(posedge sys_clk_in);
                    waited++;
                end
                if (exp_chan.size() != 0) begin
                    $display("Timeout: %0d results never arrived", exp_chan.size());
                    misc_errs++;
                    aborted = 1'b1;
                end
            end
            ENT_RAND: begin
                // Mode switches on the rising edge, away from the ready update
                @(posedge sys_clk_in);
                random_ready = tab_val[n][0];
            end
            default: begin
            end
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        seed         = 32'hf5fd_fec0;
        arst_n       = 1'b0;
        wr_en        = 1'b0;
        wr_addr      = CLR_ADDR;
        wr_chan      = '0;
        wr_data      = '0;
        sample_valid = 1'b0;
        sample_chan  = '0;
        sample_data  = '0;
        random_ready = 1'b0;
        saw_stall    = 1'b0;
        aborted      = 1'b0;
        chan_errs    = 0;
        data_errs    = 0;
        misc_errs    = 0;
        build_table();

        repeat (2) @(posedge sys_clk_in);
        @(negedge sys_clk_in);
        arst_n = 1'b1;
        @(negedge sys_clk_in);
        if (out_valid) begin
            $display("out_valid is high right after reset");
            misc_errs++;
        end
        if (!sample_ready) begin
            $display("sample_ready is low right after reset");
            misc_errs++;
        end

        for (int n = 0; n < tab_kind.size() && !aborted; n++) begin
            apply_entry(n);
        end
        if (!aborted && !saw_stall) begin
            $display("sample_ready never went low under back-pressure");
            misc_errs++;
        end

        // Quiet window, any stray result is flagged
        repeat (20) @(negedge sys_clk_in);
        $display("Errors: channel %0d, data %0d, other %0d", chan_errs, data_errs, misc_errs);
        if (chan_errs + data_errs + misc_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/pid_pkg.sv
hdl/pid_credit_if.sv
hdl/pid_coef_regs.sv
hdl/pid_filter.sv
hdl/pid_result_fifo.sv
hdl/pid_result_port.sv
hdl/pid_top.sv
tb/pid_assertions.sv
tb/pid_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PID testbench with Verilator, run it, scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pid_tb \
        -Mdir obj_dir -f filelist.f \
    && ./obj_dir/Vpid_tb 2>&1 | tee "$LOG" \
    || { echo "Build or simulation run failed"; exit 1; }

grep -q "TB FAILED" "$LOG" && { echo "Simulation reported a failure"; exit 1; }
grep -q "TB PASSED" "$LOG" || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
